//--- source/cal_pkg.sv
// shared widths and the coefficient word for the calibration front end
// gain is Q2.14 signed, so a gain of 1.0 is 16384 and the range stops just short of 2.0

package cal_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int coef_aw    = 3;             // profile address bits
  localparam int n_prof     = 2 ** coef_aw;  // eight profiles
  localparam int n_ch       = 2;             // channels sharing the read port

  localparam int gain_w     = 16;            // signed Q2.14
  localparam int gain_shift = 14;            // drop the fraction after multiply
  localparam int off_w      = 16;            // signed offset
  localparam int coef_w     = gain_w + off_w;

  ////////////////////
  // coefficient word
  ////////////////////

  // gain sits in the upper half, offset in the lower half
  typedef struct packed {
    logic signed [gain_w-1:0] gain;
    logic signed [off_w-1:0]  offset;
  } coef_t;

  // host and memory see a raw word, the channels see the fields
  typedef union packed {
    logic [coef_w-1:0] raw;
    coef_t             fld;
  } coef_word_u;

endpackage : cal_pkg

//--- source/coef_ram.sv
// profile memory, one write port and one registered read port
// contents are undefined until the host writes them, read during write returns the old word

`timescale 1ns/1ps

module coef_ram (
  input  logic                         sti,
  // host write
  input  logic                         wr_en,
  input  logic [cal_pkg::coef_aw-1:0]  wr_addr,
  input  logic [cal_pkg::coef_w-1:0]   wr_dat,   // raw coefficient word
  // arbitrated read
  input  logic                         rd_en,
  input  logic [cal_pkg::coef_aw-1:0]  rd_addr,
  output cal_pkg::coef_word_u          rd_dat
);

  import cal_pkg::*;

  ////////////////////
  // storage
  ////////////////////

  coef_word_u mem [n_prof];  // one word per profile

  // host side writes the raw view
  always_ff @(posedge sti) begin
    if (wr_en) begin
      mem[wr_addr].raw <= wr_dat;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // registered read, valid one cycle after rd_en
  // same edge as a write to that address still sees the previous word
  always_ff @(posedge sti) begin
    if (rd_en) begin
      rd_dat <= mem[rd_addr];
    end
  end

endmodule : coef_ram

//--- source/coef_arbiter.sv
// round-robin arbiter for the single memory read port
// grant is combinational from req, requesters must hold req until granted

`timescale 1ns/1ps

module coef_arbiter (
  input  logic                                          sti,
  input  logic                                          arst_n,
  input  logic [cal_pkg::n_ch-1:0]                      req,
  input  logic [cal_pkg::n_ch-1:0][cal_pkg::coef_aw-1:0] addr_in,
  output logic [cal_pkg::n_ch-1:0]                      gnt,      // one-hot or zero
  output logic                                          rd_en,
  output logic [cal_pkg::coef_aw-1:0]                   rd_addr
);

  import cal_pkg::*;

  localparam int ptr_w = (n_ch > 1) ? $clog2(n_ch) : 1;

  logic [ptr_w-1:0] last;  // last winner
  logic [ptr_w-1:0] win;   // this cycle's winner

  ////////////////////
  // pick
  ////////////////////

  // search starts just after the last winner
  always_comb begin : pick
    int idx;
    gnt = '0;
    win = last;
    for (int k = 1; k <= n_ch; k++) begin
      idx = (int'(last) + k) % n_ch;
      if (req[idx] && (gnt == '0)) begin  // first hit wins
        gnt[idx] = 1'b1;
        win      = ptr_w'(idx);
      end
    end
  end : pick

  assign rd_en = |gnt;

  // address of the winner, gnt is one-hot so a plain mux does
  always_comb begin
    rd_addr = '0;
    for (int i = 0; i < n_ch; i++) begin
      if (gnt[i]) rd_addr = addr_in[i];
    end
  end

  ////////////////////
  // pointer
  ////////////////////

  always_ff @(posedge sti or negedge arst_n) begin
    if (!arst_n) begin
      last <= ptr_w'(n_ch - 1);  // channel 0 first after reset
    end else if (rd_en) begin
      last <= win;
    end
  end

endmodule : coef_arbiter

//--- source/linear_chan.sv
// one calibration channel computing sat(((x * gain) >>> 14) + offset) in three register stages
// assumes dwo is below the sum width; new coefficients only apply to samples accepted after busy falls

`timescale 1ns/1ps

module linear_chan #(
  parameter int dwi = 14,  // input sample width
  parameter int dwo = 14   // output sample width
) (
  input  logic                         sti,
  input  logic                         arst_n,
  // sample input
  input  logic                         in_valid,
  input  logic signed [dwi-1:0]        in_dat,
  output logic                         in_ready,
  // sample output
  output logic                         out_valid,
  output logic signed [dwo-1:0]        out_dat,
  input  logic                         out_ready,
  // profile load
  input  logic                         ld,
  input  logic [cal_pkg::coef_aw-1:0]  ld_prof,
  output logic                         busy,
  // memory read through the arbiter
  output logic                         rd_req,
  output logic [cal_pkg::coef_aw-1:0]  rd_addr,
  input  logic                         rd_gnt,
  input  cal_pkg::coef_word_u          rd_dat
);

  import cal_pkg::*;

  localparam int mul_w = dwi + gain_w;                            // full product
  localparam int shf_w = mul_w - gain_shift;                      // after dropping fraction
  localparam int sum_w = ((shf_w > off_w) ? shf_w : off_w) + 1;   // never wraps

  localparam logic signed [gain_w-1:0] gain_one = gain_w'(1 << gain_shift);

  ////////////////////
  // local signals
  ////////////////////

  logic signed [gain_w-1:0] gain;    // active coefficients
  logic signed [off_w-1:0]  offset;

  logic                     fill;    // rd_dat arrives on next edge

  logic                     mul_vld;
  logic signed [mul_w-1:0]  mul_dat;
  logic signed [shf_w-1:0]  shf_dat;
  logic                     sum_vld;
  logic signed [sum_w-1:0]  sum_dat;

  logic                     s1_en;   // stage may load
  logic                     s2_en;
  logic                     s3_en;

  logic                     sat_ovf;
  logic signed [dwo-1:0]    sat_dat;

  ////////////////////
  // profile loader
  ////////////////////

  // busy covers ld, request, grant and the latch of rd_dat
  always_ff @(posedge sti or negedge arst_n) begin
    if (!arst_n) begin
      busy   <= 1'b0;
      rd_req <= 1'b0;
      fill   <= 1'b0;
      gain   <= gain_one;  // identity
      offset <= '0;
    end else begin
      if (ld && !busy) begin        // ld while pending is dropped
        busy   <= 1'b1;
        rd_req <= 1'b1;
      end
      if (rd_req && rd_gnt) begin   // memory reads on this edge
        rd_req <= 1'b0;
        fill   <= 1'b1;
      end
      if (fill) begin               // word is on rd_dat now
        fill   <= 1'b0;
        busy   <= 1'b0;
        gain   <= rd_dat.fld.gain;
        offset <= rd_dat.fld.offset;
      end
    end
  end

  // requested profile held while rd_req is up
  always_ff @(posedge sti) begin
    if (ld && !busy) begin
      rd_addr <= ld_prof;
    end
  end

  ////////////////////
  // handshake chain
  ////////////////////

  // a stage loads when the next one takes its word or it is empty
  assign s3_en    = out_ready | ~out_valid;
  assign s2_en    = s3_en     | ~sum_vld;
  assign s1_en    = s2_en     | ~mul_vld;
  assign in_ready = s1_en;                   // low only with all three full

  ////////////////////
  // stage 1, multiply
  ////////////////////

  always_ff @(posedge sti or negedge arst_n) begin
    if (!arst_n) begin
      mul_vld <= 1'b0;
    end else if (s1_en) begin
      mul_vld <= in_valid;
    end
  end

  always_ff @(posedge sti) begin
    if (in_valid && s1_en) begin
      mul_dat <= mul_w'(in_dat) * mul_w'(gain);  // full width signed product
    end
  end

  ////////////////////
  // stage 2, offset
  ////////////////////

  // arithmetic shift floors and the bits above shf_w are pure sign
  assign shf_dat = shf_w'(mul_dat >>> gain_shift);

  always_ff @(posedge sti or negedge arst_n) begin
    if (!arst_n) begin
      sum_vld <= 1'b0;
    end else if (s2_en) begin
      sum_vld <= mul_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (mul_vld && s2_en) begin
      sum_dat <= sum_w'(shf_dat) + sum_w'(offset);
    end
  end

  ////////////////////
  // stage 3, saturate
  ////////////////////

  // overflow when the bits above the output sign disagree
  assign sat_ovf = ~(&sum_dat[sum_w-1:dwo-1]) & (|sum_dat[sum_w-1:dwo-1]);
  assign sat_dat = sat_ovf ? {sum_dat[sum_w-1], {(dwo-1){~sum_dat[sum_w-1]}}}
                           : sum_dat[dwo-1:0];

  always_ff @(posedge sti or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (s3_en) begin
      out_valid <= sum_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (sum_vld && s3_en) begin
      out_dat <= sat_dat;  // clamps to max or min
    end
  end

endmodule : linear_chan

//--- source/cal_top.sv
// two calibration channels sharing one profile memory through a round-robin arbiter
// per-channel ports are packed arrays indexed by channel, no added latency here

`timescale 1ns/1ps

module cal_top #(
  parameter int dwi = 14,  // input sample width
  parameter int dwo = 14   // output sample width
) (
  input  logic                                          sti,
  input  logic                                          arst_n,
  // host write
  input  logic                                          wr_en,
  input  logic [cal_pkg::coef_aw-1:0]                   wr_addr,
  input  logic [cal_pkg::coef_w-1:0]                    wr_dat,
  // profile load, per channel
  input  logic [cal_pkg::n_ch-1:0]                      ld,
  input  logic [cal_pkg::n_ch-1:0][cal_pkg::coef_aw-1:0] ld_prof,
  output logic [cal_pkg::n_ch-1:0]                      busy,
  // samples, per channel
  input  logic [cal_pkg::n_ch-1:0]                      in_valid,
  input  logic [cal_pkg::n_ch-1:0][dwi-1:0]             in_dat,
  output logic [cal_pkg::n_ch-1:0]                      in_ready,
  output logic [cal_pkg::n_ch-1:0]                      out_valid,
  output logic [cal_pkg::n_ch-1:0][dwo-1:0]             out_dat,
  input  logic [cal_pkg::n_ch-1:0]                      out_ready
);

  import cal_pkg::*;

  ////////////////////
  // memory side
  ////////////////////

  logic [n_ch-1:0]              rd_req;   // per channel
  logic [n_ch-1:0]              rd_gnt;   // one-hot
  logic [n_ch-1:0][coef_aw-1:0] rd_addr_ch;
  logic                         rd_en;
  logic [coef_aw-1:0]           rd_addr;
  coef_word_u                   rd_dat;   // shared by both channels

  coef_ram i_coef_ram (
    .sti     (sti),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

  coef_arbiter i_coef_arbiter (
    .sti     (sti),
    .arst_n  (arst_n),
    .req     (rd_req),
    .addr_in (rd_addr_ch),
    .gnt     (rd_gnt),
    .rd_en   (rd_en),
    .rd_addr (rd_addr)
  );

  ////////////////////
  // channels
  ////////////////////

  for (genvar i = 0; i < n_ch; i++) begin : g_chan
    linear_chan #(
      .dwi (dwi),
      .dwo (dwo)
    ) i_chan (
      .sti       (sti),
      .arst_n    (arst_n),
      .in_valid  (in_valid[i]),
      .in_dat    (in_dat[i]),
      .in_ready  (in_ready[i]),
      .out_valid (out_valid[i]),
      .out_dat   (out_dat[i]),
      .out_ready (out_ready[i]),
      .ld        (ld[i]),
      .ld_prof   (ld_prof[i]),
      .busy      (busy[i]),
      .rd_req    (rd_req[i]),
      .rd_addr   (rd_addr_ch[i]),
      .rd_gnt    (rd_gnt[i]),
      .rd_dat    (rd_dat)   // only the granted channel latches it
    );
  end : g_chan

endmodule : cal_top

//--- bench/cal_chk.sv
// handshake, arbitration and reset checks bound into cal_top
// the two-cycle grant bound holds for two requesters only

`timescale 1ns/1ps

module cal_chk #(
  parameter int dwo = 14
) (
  input logic                                sti,
  input logic                                arst_n,
  input logic [cal_pkg::n_ch-1:0]            rd_req,
  input logic [cal_pkg::n_ch-1:0]            rd_gnt,
  input logic [cal_pkg::n_ch-1:0]            busy,
  input logic [cal_pkg::n_ch-1:0]            out_valid,
  input logic [cal_pkg::n_ch-1:0]            out_ready,
  input logic [cal_pkg::n_ch-1:0][dwo-1:0]   out_dat
);

  import cal_pkg::*;

  int unsigned fail_cnt = 0;  // failed checks so far

  ////////////////////
  // arbiter
  ////////////////////

  gnt_onehot: assert property (@(posedge sti) disable iff (!arst_n) $onehot0(rd_gnt))
    else begin
      fail_cnt++;
      $error("rd_gnt is not one-hot");
    end

  gnt_has_req: assert property (@(posedge sti) disable iff (!arst_n) (rd_gnt & ~rd_req) == '0)
    else begin
      fail_cnt++;
      $error("grant without a request");
    end

  // everything quiet while in reset
  rst_quiet: assert property (@(posedge sti)
      !arst_n |-> (out_valid == '0) && (busy == '0) && (rd_req == '0))
    else begin
      fail_cnt++;
      $error("outputs active during reset");
    end

  ////////////////////
  // per channel
  ////////////////////

  for (genvar i = 0; i < n_ch; i++) begin : g_ch
    // held request served within two cycles
    req_served: assert property (@(posedge sti) disable iff (!arst_n)
        rd_req[i] && !rd_gnt[i] |=> rd_gnt[i])
      else begin
        fail_cnt++;
        $error("request of channel %0d not granted in time", i);
      end

    // stalled output holds valid and data
    out_hold: assert property (@(posedge sti) disable iff (!arst_n)
        out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_dat[i]))
      else begin
        fail_cnt++;
        $error("output of channel %0d changed under stall", i);
      end
  end : g_ch

endmodule : cal_chk

//--- bench/cal_tb.sv
// LFSR streams on both channels of cal_top checked against a floor, offset and clamp model
// assumes the default 14-bit widths; profiles change only while a channel is idle and drained

`timescale 1ns/1ps

module cal_tb;

  import cal_pkg::*;

  localparam int dwi     = 14;
  localparam int dwo     = 14;
  localparam int clk_ns  = 8;
  localparam int in_max  = 2 ** (dwi - 1) - 1;
  localparam int in_min  = -(2 ** (dwi - 1));
  localparam int out_max = 2 ** (dwo - 1) - 1;
  localparam int out_min = -(2 ** (dwo - 1));

  // sample counts per test with both channels side by side
  localparam int n_ident  = 300;
  localparam int n_rounds = 4;
  localparam int n_round  = 60;
  localparam int n_sat    = 100;
  localparam int n_bp     = 300;
  localparam int n_arb    = 60;
  localparam int total_samples = n_ident + n_rounds * n_round + n_sat + n_bp + n_arb;
  localparam int wd_cycles     = total_samples * 4 + 1500;  // margin for reset, writes, loads

  logic                          sti;
  logic                          arst_n;
  logic                          wr_en;
  logic [coef_aw-1:0]            wr_addr;
  logic [coef_w-1:0]             wr_dat;
  logic [n_ch-1:0]               ld;
  logic [n_ch-1:0][coef_aw-1:0]  ld_prof;
  logic [n_ch-1:0]               busy;
  logic [n_ch-1:0]               in_valid;
  logic [n_ch-1:0][dwi-1:0]      in_dat;
  logic [n_ch-1:0]               in_ready;
  logic [n_ch-1:0]               out_valid;
  logic [n_ch-1:0][dwo-1:0]      out_dat;
  logic [n_ch-1:0]               out_ready;

  // host profiles with gain 0.5, negative gains, big offsets and near 2.0 for clamping
  int prof_gain [n_prof] = '{16384, 8192, -16384, -8192, 24576, 12000, 32767, 32767};
  int prof_off  [n_prof] = '{0, 100, 0, -1500, 4000, -6000, 8000, -8000};

  int          model_gain [n_ch];  // coefficients the model believes are active
  int          model_off  [n_ch];
  int          exp_q [n_ch][$];    // expected outputs in order
  logic [n_ch-1:0] took;           // input transfer seen at the last edge
  string       test_name = "reset";
  logic [15:0] lfsr = 16'd8;
  int          seq_errs = 0;       // errors from the sequencing tasks
  int          mon_errs = 0;       // errors from the output monitor

  cal_top #(
    .dwi (dwi),
    .dwo (dwo)
  ) i_cal_top (
    .sti       (sti),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat),
    .ld        (ld),
    .ld_prof   (ld_prof),
    .busy      (busy),
    .in_valid  (in_valid),
    .in_dat    (in_dat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_dat   (out_dat),
    .out_ready (out_ready)
  );

  bind cal_top cal_chk #(.dwo(dwo)) i_cal_chk (
    .sti       (sti),
    .arst_n    (arst_n),
    .rd_req    (rd_req),
    .rd_gnt    (rd_gnt),
    .busy      (busy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_dat   (out_dat)
  );

  initial begin
    sti = 1'b0;
    forever #(clk_ns / 2) sti = ~sti;
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr stepped once per bit handed out
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // full scale picks the rails often
  function automatic int new_sample(input bit full);
    int sel;
    sel = full ? take_bits(2) : 3;
    if (sel == 0) return in_max;
    if (sel == 1) return in_min;
    return take_bits(dwi) + in_min;
  endfunction

  // clamp(floor(x * g / 16384) + o)
  function automatic int model_cal(input int x, input int g, input int o);
    longint p;
    longint q;
    p = longint'(x) * longint'(g);
    q = p / 16384;
    if ((p % 16384) != 0 && p < 0) q = q - 1;  // step a truncated negative quotient down to floor
    q = q + longint'(o);
    if (q > longint'(out_max)) q = longint'(out_max);
    if (q < longint'(out_min)) q = longint'(out_min);
    return int'(q);
  endfunction

  task automatic write_profile(input int p);
    @(posedge sti);
    #1;
    wr_en   = 1'b1;
    wr_addr = coef_aw'(p);
    wr_dat  = {16'(prof_gain[p]), 16'(prof_off[p])};  // gain high, offset low
    @(posedge sti);
    #1;
    wr_en = 1'b0;
  endtask

  // strobe ld on the selected channels in one cycle and wait for busy to drop
  task automatic load_profiles(input logic [n_ch-1:0] sel, input int p0, input int p1);
    int prof [n_ch];
    int waited;
    prof[0] = p0;
    prof[1] = p1;
    @(posedge sti);
    #1;
    ld         = sel;
    ld_prof[0] = coef_aw'(p0);
    ld_prof[1] = coef_aw'(p1);
    @(posedge sti);
    #1;
    ld = '0;
    assert ((busy & sel) == sel) else begin
      seq_errs++;
      $display("busy did not rise after ld on channels %b in test %s", sel, test_name);
    end
    waited = 0;
    while ((busy & sel) != '0 && waited < 10) begin
      @(posedge sti);
      #1;
      waited++;
    end
    assert ((busy & sel) == '0) else begin
      seq_errs++;
      $display("profile load on channels %b never finished in test %s", sel, test_name);
    end
    for (int c = 0; c < n_ch; c++) begin
      if (sel[c]) begin
        model_gain[c] = prof_gain[prof[c]];
        model_off[c]  = prof_off[prof[c]];
      end
    end
  endtask

  // n samples per channel with random gaps and optional out_ready stalls
  task automatic run_stream(input string name, input int n, input bit stall, input bit full);
    int sent [n_ch];
    test_name = name;
    for (int c = 0; c < n_ch; c++) sent[c] = 0;
    while (sent[0] < n || sent[1] < n) begin
      @(posedge sti);
      #1;
      for (int c = 0; c < n_ch; c++) begin
        if (took[c]) sent[c]++;
        if (in_valid[c] && !took[c]) begin
          in_valid[c] = 1'b1;                  // hold until accepted
        end else if (sent[c] < n && take_bits(2) != 0) begin
          in_valid[c] = 1'b1;
          in_dat[c]   = dwi'(new_sample(full));
        end else begin
          in_valid[c] = 1'b0;
        end
        out_ready[c] = stall ? (take_bits(1) == 1) : 1'b1;
      end
    end
    #1;
    out_ready = '1;
  endtask

  // outputs left over after the pipeline should have emptied count as missing
  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q[0].size() + exp_q[1].size()) > 0 && waited < 40) begin
      @(posedge sti);
      #1;
      waited++;
    end
    for (int c = 0; c < n_ch; c++) begin
      assert (exp_q[c].size() == 0) else begin
        seq_errs++;
        $display("channel %0d is missing %0d outputs in test %s", c, exp_q[c].size(), test_name);
      end
    end
  endtask

  ////////////////////
  // output monitor
  ////////////////////

  always @(posedge sti) begin : monitor
    int exp_v;
    int got_v;
    for (int c = 0; c < n_ch; c++) begin
      took[c] = in_valid[c] & in_ready[c];
      if (took[c]) begin
        exp_q[c].push_back(model_cal(int'($signed(in_dat[c])), model_gain[c], model_off[c]));
      end
      if (out_valid[c] && out_ready[c]) begin
        assert (exp_q[c].size() > 0) else begin
          mon_errs++;
          $display("channel %0d gave an output with no sample pending in test %s", c, test_name);
        end
        if (exp_q[c].size() > 0) begin
          exp_v = exp_q[c].pop_front();
          got_v = int'($signed(out_dat[c]));
          assert (got_v == exp_v) else begin
            mon_errs++;
            $display("mismatch %s ch%0d expected %0d actual %0d", test_name, c, exp_v, got_v);
          end
        end
      end
    end
  end : monitor

  ////////////////////
  // sequence
  ////////////////////

  initial begin : main
    int rnd_p0 [n_rounds];
    int rnd_p1 [n_rounds];
    int chk_errs;
    rnd_p0 = '{1, 3, 5, 2};
    rnd_p1 = '{2, 4, 0, 5};
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_dat    = '0;
    ld        = '0;
    ld_prof   = '0;
    in_valid  = '0;
    in_dat    = '0;
    out_ready = '1;
    arst_n    = 1'b1;
    for (int c = 0; c < n_ch; c++) begin
      model_gain[c] = 16384;  // identity after reset
      model_off[c]  = 0;
    end
    #1 arst_n = 1'b0;
    repeat (16) @(posedge sti);
    #1 arst_n = 1'b1;

    run_stream("identity", n_ident, 1'b0, 1'b0);
    drain();

    test_name = "gain_offset";
    for (int p = 0; p < n_prof; p++) write_profile(p);
    for (int r = 0; r < n_rounds; r++) begin
      load_profiles(2'b01, rnd_p0[r], 0);
      load_profiles(2'b10, 0, rnd_p1[r]);
      run_stream("gain_offset", n_round, 1'b0, 1'b0);
      drain();
    end

    test_name = "saturation";
    load_profiles(2'b01, 6, 0);
    load_profiles(2'b10, 0, 7);
    run_stream("saturation", n_sat, 1'b0, 1'b1);
    drain();

    test_name = "backpressure";
    load_profiles(2'b01, 1, 0);
    load_profiles(2'b10, 0, 3);
    run_stream("backpressure", n_bp, 1'b1, 1'b0);
    drain();

    test_name = "arbitration";
    load_profiles(2'b11, 4, 5);  // same cycle so both compete for the read port
    run_stream("arbitration", n_arb, 1'b0, 1'b0);
    drain();

    chk_errs = int'(i_cal_top.i_cal_chk.fail_cnt);
    $display("errors: %0d sequence, %0d monitor, %0d assertion", seq_errs, mon_errs, chk_errs);
    if (seq_errs + mon_errs + chk_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end : main

  // whole run bounded by the summed test lengths
  initial begin : watchdog
    #(wd_cycles * clk_ns);
    $display("timeout after %0d cycles, test %s did not finish", wd_cycles, test_name);
    $display("Simulation failed");
    $finish;
  end : watchdog

endmodule : cal_tb

//--- calib.f
source/cal_pkg.sv
source/coef_ram.sv
source/coef_arbiter.sv
source/linear_chan.sv
source/cal_top.sv
bench/cal_chk.sv
bench/cal_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, judge the result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module cal_tb -f calib.f -o cal_sim

sim_rc=0
./obj_dir/cal_sim +verilator+error+limit+1000 > sim.log 2>&1 || sim_rc=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log || [ "$sim_rc" -ne 0 ]; then
  echo "simulation ended without a pass result"
  exit 1
fi
exit 0
